// File: hdl/bp_pkg.sv
package bp_pkg;

    // instruction address width
    localparam int xlen = 32;

    // word address width of stored targets
    localparam int word_bits = xlen - 2;

    // widest tag the entry can hold
    localparam int max_tag_bits = 24;

    localparam logic [xlen-1:0] reset_pc = '0;

    // 2-bit saturating counter where 2 and 3 predict taken
    typedef logic [1:0] bht_ctr_t;

    localparam bht_ctr_t ctr_weak_taken     = 2'd2;
    localparam bht_ctr_t ctr_weak_not_taken = 2'd1;

    typedef struct packed {
        logic                    valid;
        logic [max_tag_bits-1:0] tag;
        logic [word_bits-1:0]    target;
        bht_ctr_t                ctr;
    } btb_entry_t;

    // one resolved branch from execute
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
        logic            taken;
    } br_resolve_t;

    // write request from the resolver into the table
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
        logic            taken;
    } bp_update_t;

    function automatic logic ctr_taken(bht_ctr_t ctr);
        return ctr[1];
    endfunction

    // saturates at 0 and 3
    function automatic bht_ctr_t ctr_train(bht_ctr_t ctr, logic taken);
        bht_ctr_t nxt;
        nxt = ctr;
        if (taken && ctr != 2'd3) begin
            nxt = ctr + 2'd1;
        end else if (!taken && ctr != 2'd0) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage

// File: hdl/btb_bht.sv
`timescale 1ns/100ps

module btb_bht import bp_pkg::*; #(
    parameter int LOG_SIZE = 5,
    parameter int TAG_BITS = 13
) (
    input  logic            clk_in,
    input  logic            rst_in,

    // fetch side lookup
    input  logic [xlen-1:0] rd_a_pc,
    output logic            rd_a_hit,
    output logic            rd_a_taken,
    output logic [xlen-1:0] rd_a_target,

    // resolver side lookup
    input  logic [xlen-1:0] rd_b_pc,
    output logic            rd_b_taken,
    output logic [xlen-1:0] rd_b_target,

    input  logic            upd_valid,
    input  bp_update_t      upd
);

    localparam int entries = 1 << LOG_SIZE;

    btb_entry_t              table_q [entries];

    btb_entry_t              ent_a;
    btb_entry_t              ent_b;
    logic                    hit_a;
    logic                    hit_b;

    logic [LOG_SIZE-1:0]     upd_idx;
    btb_entry_t              upd_old;
    btb_entry_t              upd_entry;

    // word index since pc[1:0] is always zero
    function automatic logic [LOG_SIZE-1:0] pc_index(logic [xlen-1:0] pc);
        return pc[2 +: LOG_SIZE];
    endfunction

    // tag bits above the index zero extended to the stored width
    function automatic logic [max_tag_bits-1:0] pc_tag(logic [xlen-1:0] pc);
        logic [max_tag_bits-1:0] t;
        t = '0;
        t[TAG_BITS-1:0] = pc[2 + LOG_SIZE +: TAG_BITS];
        return t;
    endfunction

    function automatic logic tag_hit(btb_entry_t e, logic [xlen-1:0] pc);
        return e.valid && (e.tag == pc_tag(pc));
    endfunction

    // port A
    assign ent_a       = table_q[pc_index(rd_a_pc)];
    assign hit_a       = tag_hit(ent_a, rd_a_pc);
    assign rd_a_hit    = hit_a;
    assign rd_a_taken  = hit_a && ctr_taken(ent_a.ctr);
    assign rd_a_target = {ent_a.target, 2'b00};

    // port B applies the same test to the resolving pc
    assign ent_b       = table_q[pc_index(rd_b_pc)];
    assign hit_b       = tag_hit(ent_b, rd_b_pc);
    assign rd_b_taken  = hit_b && ctr_taken(ent_b.ctr);
    assign rd_b_target = {ent_b.target, 2'b00};

    // allocate on miss and train on hit
    assign upd_idx = pc_index(upd.pc);
    assign upd_old = table_q[upd_idx];

    always_comb begin
        upd_entry.valid  = 1'b1;
        upd_entry.tag    = pc_tag(upd.pc);
        upd_entry.target = upd.target[xlen-1:2];
        if (tag_hit(upd_old, upd.pc)) begin
            upd_entry.ctr = ctr_train(upd_old.ctr, upd.taken);
        end else if (upd.taken) begin
            upd_entry.ctr = ctr_weak_taken;
        end else begin
            upd_entry.ctr = ctr_weak_not_taken;
        end
    end

    // reset invalidates every entry
    always_ff @(posedge clk_in) begin
        if (!rst_in) begin
            for (int i = 0; i < entries; i++) begin
                table_q[i].valid <= 1'b0;
            end
        end else if (upd_valid) begin
            table_q[upd_idx] <= upd_entry;
        end
    end

    // one write per handshake, so never back to back
    a_upd_single: assert property (
        @(posedge clk_in) disable iff (!rst_in)
        upd_valid |=> !upd_valid
    );

endmodule

// File: hdl/branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve import bp_pkg::*; (
    input  logic            clk_in,
    input  logic            rst_in,

    // four-phase channel from execute
    input  logic            res_req,
    input  br_resolve_t     res,
    output logic            res_ack,

    // lookup of what fetch predicted for res.pc
    output logic [xlen-1:0] pred_pc,
    input  logic            pred_taken,
    input  logic [xlen-1:0] pred_target,

    output logic            upd_valid,
    output bp_update_t      upd,

    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    logic            sample;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] predicted_next;
    logic [xlen-1:0] actual_next;
    logic            mispredict;

    // first edge with req high and ack low takes the request
    assign sample = res_req && !res_ack;

    assign pred_pc = res.pc;
    assign seq_pc  = res.pc + xlen'(4);

    assign predicted_next = pred_taken ? pred_target : seq_pc;
    assign actual_next    = res.taken ? res.target : seq_pc;
    assign mispredict     = predicted_next != actual_next;

    assign upd_valid  = sample;
    assign upd.pc     = res.pc;
    assign upd.target = res.target;
    assign upd.taken  = res.taken;

    // redirect lands in fetch on the sampling edge
    assign redirect_valid = sample && mispredict;
    assign redirect_pc    = actual_next;

    // ack rises with the sample and falls one edge after req drops
    always_ff @(posedge clk_in) begin
        if (!rst_in) begin
            res_ack <= 1'b0;
        end else if (sample) begin
            res_ack <= 1'b1;
        end else if (!res_req && res_ack) begin
            res_ack <= 1'b0;
        end
    end

    // payload held for the whole req phase
    a_res_stable: assert property (
        @(posedge clk_in) disable iff (!rst_in)
        (res_req && $past(res_req)) |-> $stable(res)
    );

    // execute must wait for ack to fall
    a_req_after_ack: assert property (
        @(posedge clk_in) disable iff (!rst_in)
        $rose(res_req) |-> !res_ack
    );

endmodule

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen import bp_pkg::*; (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,

    // mispredict from the resolver
    input  logic            redirect_valid,
    input  logic [xlen-1:0] redirect_pc,

    // prediction for the current fetch pc
    output logic [xlen-1:0] lookup_pc,
    input  logic            pred_taken,
    input  logic [xlen-1:0] pred_target,

    output logic [xlen-1:0] fetch_pc,
    output logic            fetch_pred_taken,
    output logic            flush
);

    logic [xlen-1:0] next_pc;

    assign lookup_pc = fetch_pc;

    // predicted target or fall through
    assign next_pc = pred_taken ? pred_target : fetch_pc + xlen'(4);

    // redirect wins over a stall
    always_ff @(posedge clk_in) begin
        if (!rst_in) begin
            fetch_pc         <= reset_pc;
            fetch_pred_taken <= 1'b0;
            flush            <= 1'b0;
        end else if (redirect_valid) begin
            fetch_pc         <= redirect_pc;
            fetch_pred_taken <= 1'b0;
            flush            <= 1'b1;
        end else if (rdy_in) begin
            fetch_pc         <= next_pc;
            fetch_pred_taken <= pred_taken;
            flush            <= 1'b0;
        end else begin
            flush            <= 1'b0;
        end
    end

    // targets from table and execute must stay word aligned
    a_pc_aligned: assert property (
        @(posedge clk_in) disable iff (!rst_in)
        fetch_pc[1:0] == 2'b00
    );

endmodule

// File: hdl/branch_predict_top.sv
`timescale 1ns/100ps

module branch_predict_top import bp_pkg::*; #(
    parameter int LOG_SIZE = 5,
    parameter int TAG_BITS = 13
) (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,

    output logic [xlen-1:0] fetch_pc,
    output logic            fetch_pred_taken,
    output logic            flush,

    input  logic            res_req,
    input  br_resolve_t     res,
    output logic            res_ack
);

    logic [xlen-1:0] lookup_pc;
    logic            lookup_taken;
    logic [xlen-1:0] lookup_target;

    logic [xlen-1:0] pred_pc;
    logic            pred_taken;
    logic [xlen-1:0] pred_target;

    logic            upd_valid;
    bp_update_t      upd;

    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;

    btb_bht #(
        .LOG_SIZE (LOG_SIZE),
        .TAG_BITS (TAG_BITS)
    ) u_btb_bht (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rd_a_pc     (lookup_pc),
        // fetch only needs the taken decision
        .rd_a_hit    (),
        .rd_a_taken  (lookup_taken),
        .rd_a_target (lookup_target),
        .rd_b_pc     (pred_pc),
        .rd_b_taken  (pred_taken),
        .rd_b_target (pred_target),
        .upd_valid   (upd_valid),
        .upd         (upd)
    );

    branch_resolve u_branch_resolve (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .res_req        (res_req),
        .res            (res),
        .res_ack        (res_ack),
        .pred_pc        (pred_pc),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .upd_valid      (upd_valid),
        .upd            (upd),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .rdy_in           (rdy_in),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .lookup_pc        (lookup_pc),
        .pred_taken       (lookup_taken),
        .pred_target      (lookup_target),
        .fetch_pc         (fetch_pc),
        .fetch_pred_taken (fetch_pred_taken),
        .flush            (flush)
    );

endmodule

// File: verification/tb_branch_predict.sv
`timescale 1ns/100ps

module tb_branch_predict import bp_pkg::*; ();

    localparam int log_size     = 5;
    localparam int tag_bits     = 13;
    localparam int entries      = 1 << log_size;
    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    localparam int n_directed   = 9;
    localparam int n_random     = 200;
    localparam int n_handshakes = n_directed + n_random;

    logic            clk_in = 1'b0;
    logic            rst_in;
    logic            rdy_in;
    logic [xlen-1:0] fetch_pc;
    logic            fetch_pred_taken;
    logic            flush;
    logic            res_req;
    br_resolve_t     res;
    logic            res_ack;

    // model of the table
    logic                m_valid  [entries];
    logic [tag_bits-1:0] m_tag    [entries];
    logic [xlen-1:0]     m_target [entries];
    logic [1:0]          m_ctr    [entries];

    // expected DUT outputs stepped on every rising edge
    logic            model_live;
    logic [xlen-1:0] exp_pc;
    logic            exp_pred_taken;
    logic            exp_flush;
    logic            exp_ack;

    string           test_name;
    logic            rdy_random;
    logic            last_flush;

    branch_predict_top #(
        .LOG_SIZE (log_size),
        .TAG_BITS (tag_bits)
    ) dut (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .rdy_in           (rdy_in),
        .fetch_pc         (fetch_pc),
        .fetch_pred_taken (fetch_pred_taken),
        .flush            (flush),
        .res_req          (res_req),
        .res              (res),
        .res_ack          (res_ack)
    );

    initial begin
        forever begin
            #(clk_period / 2) clk_in = ~clk_in;
        end
    end

    task automatic stop_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string what, logic [xlen-1:0] expected,
                               logic [xlen-1:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAIL %s: expected %h, actual %h", what, expected, actual));
        end
    endtask

    function automatic logic [log_size-1:0] idx_of(logic [xlen-1:0] pc);
        return pc[2 +: log_size];
    endfunction

    function automatic logic [tag_bits-1:0] tag_of(logic [xlen-1:0] pc);
        return pc[2 + log_size +: tag_bits];
    endfunction

    function automatic logic predict_taken(logic [xlen-1:0] pc);
        logic [log_size-1:0] i;
        i = idx_of(pc);
        return m_valid[i] && (m_tag[i] == tag_of(pc)) && (m_ctr[i] >= 2'd2);
    endfunction

    // expected next pc after pc, from the model table
    function automatic logic [xlen-1:0] predict_next(logic [xlen-1:0] pc);
        logic [xlen-1:0] nxt;
        if (predict_taken(pc)) begin
            nxt = m_target[idx_of(pc)];
        end else begin
            nxt = pc + 32'd4;
        end
        return nxt;
    endfunction

    // allocate on miss and train on hit
    task automatic model_update(logic [xlen-1:0] pc, logic [xlen-1:0] target, logic taken);
        logic [log_size-1:0] i;
        i = idx_of(pc);
        if (m_valid[i] && m_tag[i] == tag_of(pc)) begin
            if (taken && m_ctr[i] != 2'd3) begin
                m_ctr[i] = m_ctr[i] + 2'd1;
            end else if (!taken && m_ctr[i] != 2'd0) begin
                m_ctr[i] = m_ctr[i] - 2'd1;
            end
        end else begin
            m_ctr[i] = taken ? 2'd2 : 2'd1;
        end
        m_valid[i]  = 1'b1;
        m_tag[i]    = tag_of(pc);
        m_target[i] = {target[xlen-1:2], 2'b00};
    endtask

    always @(posedge clk_in) begin : model_step
        logic            take;
        logic [xlen-1:0] actual;
        logic            fetch_taken;
        logic [xlen-1:0] fetch_next;
        if (!rst_in) begin
            for (int i = 0; i < entries; i++) begin
                m_valid[i] = 1'b0;
            end
            exp_pc         = reset_pc;
            exp_pred_taken = 1'b0;
            exp_flush      = 1'b0;
            exp_ack        = 1'b0;
            model_live     = 1'b1;
        end else begin
            // fetch and resolver both see the table before this edge's write
            fetch_taken = predict_taken(exp_pc);
            fetch_next  = predict_next(exp_pc);
            take        = res_req && !exp_ack;
            actual      = res.taken ? res.target : res.pc + 32'd4;
            exp_flush   = take && (predict_next(res.pc) != actual);
            if (exp_flush) begin
                exp_pc         = actual;
                exp_pred_taken = 1'b0;
            end else if (rdy_in) begin
                exp_pc         = fetch_next;
                exp_pred_taken = fetch_taken;
            end
            if (take) begin
                model_update(res.pc, res.target, res.taken);
                exp_ack = 1'b1;
            end else if (!res_req) begin
                exp_ack = 1'b0;
            end
        end
    end

    always @(negedge clk_in) begin
        if (model_live) begin
            check_value({test_name, " fetch_pc"}, exp_pc, fetch_pc);
            check_value({test_name, " fetch_pred_taken"}, xlen'(exp_pred_taken),
                        xlen'(fetch_pred_taken));
            check_value({test_name, " flush"}, xlen'(exp_flush), xlen'(flush));
            check_value({test_name, " res_ack"}, xlen'(exp_ack), xlen'(res_ack));
        end
    end

    task automatic next_cycle();
        @(negedge clk_in);
        if (rdy_random) begin
            rdy_in = ($urandom_range(0, 3) != 0);
        end
    endtask

    // one four-phase handshake
    task automatic resolve_branch(logic [xlen-1:0] pc, logic [xlen-1:0] target,
                                  logic taken, int gap, int hold);
        logic [xlen-1:0] actual;
        logic            mis;
        repeat (gap) next_cycle();
        actual     = taken ? target : pc + 32'd4;
        mis        = predict_next(pc) != actual;
        res.pc     = pc;
        res.target = target;
        res.taken  = taken;
        res_req    = 1'b1;
        next_cycle();
        check_value({test_name, " ack after one edge"}, 32'd1, xlen'(res_ack));
        check_value({test_name, " mispredict flush"}, xlen'(mis), xlen'(flush));
        if (mis) begin
            check_value({test_name, " redirect pc"}, actual, fetch_pc);
        end
        last_flush = flush;
        repeat (hold) next_cycle();
        res_req = 1'b0;
        next_cycle();
        check_value({test_name, " ack release"}, 32'd0, xlen'(res_ack));
    endtask

    initial begin : stimulus
        logic            found;
        logic [xlen-1:0] hold_pc;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
        logic            taken;
        void'($urandom(8138));
        rst_in     = 1'b0;
        rdy_in     = 1'b0;
        res_req    = 1'b0;
        res        = '0;
        rdy_random = 1'b0;
        model_live = 1'b0;
        last_flush = 1'b0;
        test_name  = "reset";
        repeat (reset_cycles) next_cycle();
        rst_in = 1'b1;

        test_name = "sequential";
        check_value("reset pc", reset_pc, fetch_pc);
        check_value("reset flush", 32'd0, xlen'(flush));
        rdy_in = 1'b1;
        for (int i = 1; i <= 8; i++) begin
            next_cycle();
            check_value("sequential pc", reset_pc + 32'(4 * i), fetch_pc);
        end
        test_name = "stall";
        rdy_in    = 1'b0;
        hold_pc   = fetch_pc;
        repeat (4) begin
            next_cycle();
            check_value("stall pc", hold_pc, fetch_pc);
        end

        test_name = "taken untrained";
        rdy_in    = 1'b1;
        resolve_branch(32'h40, 32'h20, 1'b1, 0, 0);
        check_value("taken untrained flush", 32'd1, xlen'(last_flush));
        found = 1'b0;
        for (int n = 0; n < 64 && !found; n++) begin
            next_cycle();
            found = (fetch_pc == 32'h40);
        end
        if (!found) begin
            stop_run("fetch never came back to the branch at 0x40");
        end
        next_cycle();
        check_value("taken loop pc", 32'h20, fetch_pc);
        check_value("taken loop pred", 32'd1, xlen'(fetch_pred_taken));

        test_name = "train up";
        repeat (2) resolve_branch(32'h40, 32'h20, 1'b1, 1, 0);
        test_name = "train down";
        repeat (4) resolve_branch(32'h40, 32'h20, 1'b0, 2, 1);

        // 0x40 and 0xc0 share index 16 with tags 0 and 1
        test_name = "evict";
        resolve_branch(32'hc0, 32'h100, 1'b1, 1, 0);
        check_value("evict by 0xc0", 32'd1, xlen'(last_flush));
        resolve_branch(32'h40, 32'h100, 1'b1, 3, 0);
        check_value("evict by 0x40", 32'd1, xlen'(last_flush));

        rdy_random = 1'b1;
        for (int k = 0; k < n_random; k++) begin
            test_name = $sformatf("random %0d", k);
            pc        = $urandom_range(0, 255) << 2;
            target    = $urandom_range(0, 255) << 2;
            taken     = $urandom_range(0, 1) == 1;
            resolve_branch(pc, target, taken, int'($urandom_range(0, 3)),
                           int'($urandom_range(0, 2)));
        end
        rdy_random = 1'b0;
        repeat (4) next_cycle();
        $display("TB PASSED");
        $finish;
    end

    // allowance per handshake plus reset
    initial begin
        #((n_handshakes * 20 + reset_cycles) * clk_period);
        stop_run("timeout: the run did not finish in the expected number of cycles");
    end

endmodule

// File: branch_predict_top.f
hdl/bp_pkg.sv
hdl/btb_bht.sv
hdl/branch_resolve.sv
hdl/fetch_pc_gen.sv
hdl/branch_predict_top.sv
verification/tb_branch_predict.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_branch_predict \
    -f branch_predict_top.f \
    -o sim_branch_predict || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_branch_predict 2>&1)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
